// ==== common/cache_pkg.sv ====
package cache_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////

    // two instruction fetchers share the cache
    localparam int NUM_CONSUMERS = 2;
    localparam int ADDR_BITS     = 8;
    // memory and consumer buses carry one chunk
    localparam int CHUNK_BITS    = 8;
    // addr = [tag][index][offset]
    localparam int OFFSET_BITS   = 1;
    localparam int INDEX_BITS    = 4;
    localparam int TAG_BITS      = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_CHUNKS    = 2 ** OFFSET_BITS;
    localparam int NUM_LINES     = 2 ** INDEX_BITS;
    localparam int LINE_BITS     = CHUNK_BITS * NUM_CHUNKS;

    // widths with a meaning
    typedef logic [ADDR_BITS-1:0]              addr_t;
    typedef logic [CHUNK_BITS-1:0]             chunk_t;
    typedef logic [TAG_BITS-1:0]               tag_t;
    typedef logic [INDEX_BITS-1:0]             index_t;
    typedef logic [OFFSET_BITS-1:0]            offset_t;
    typedef logic [LINE_BITS-1:0]              line_data_t;
    typedef logic [$clog2(NUM_CONSUMERS)-1:0]  consumer_id_t;

    ////////////////////////////////////////
    // handshake and internal bundles
    ////////////////////////////////////////

    // four-phase req/ack on both sides
    typedef struct packed {logic req; addr_t addr;} cons_req_t;
    typedef struct packed {logic ack; chunk_t data;} cons_rsp_t;
    typedef struct packed {logic req; addr_t addr;} mem_req_t;
    typedef struct packed {logic ack; chunk_t data;} mem_rsp_t;

    // arbiter offer, addr is the line base
    typedef struct packed {logic valid; addr_t addr;} refill_cmd_t;

    // whole-line commit from the refill engine
    typedef struct packed {
        logic       valid;
        index_t     index;
        tag_t       tag;
        line_data_t data;
    } line_fill_t;

    typedef enum logic [1:0] {PORT_IDLE, PORT_MISS, PORT_RELAY} port_state_e;
    typedef enum logic [1:0] {RF_IDLE, RF_REQ, RF_RELEASE, RF_COMMIT} refill_state_e;

endpackage

// ==== design/line_store.sv ====
`timescale 1ns/1ps

module line_store (
    input  logic                   clk,
    input  logic                   reset,
    input  cache_pkg::addr_t       lookup_addr_i [cache_pkg::NUM_CONSUMERS],
    output logic                   lookup_hit_o [cache_pkg::NUM_CONSUMERS],
    output cache_pkg::chunk_t      lookup_data_o [cache_pkg::NUM_CONSUMERS],
    input  cache_pkg::line_fill_t  fill_i
);

    // per-line state, only valid is control
    logic                  line_valid [cache_pkg::NUM_LINES];
    cache_pkg::tag_t       line_tag [cache_pkg::NUM_LINES];
    cache_pkg::line_data_t line_data [cache_pkg::NUM_LINES];

    ////////////////////////////////////////
    // lookups, one per consumer
    ////////////////////////////////////////

    for (genvar g = 0; g < cache_pkg::NUM_CONSUMERS; g++) begin : g_lookup
        cache_pkg::tag_t    req_tag;
        cache_pkg::index_t  req_index;
        cache_pkg::offset_t req_offset;

        // split the address into its fields
        assign req_tag    = lookup_addr_i[g][cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
        assign req_index  = lookup_addr_i[g][cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
        assign req_offset = lookup_addr_i[g][0 +: cache_pkg::OFFSET_BITS];

        assign lookup_hit_o[g] = line_valid[req_index] && (line_tag[req_index] == req_tag);
        // chunk 0 sits in the low bits of the line
        assign lookup_data_o[g] =
            line_data[req_index][req_offset * cache_pkg::CHUNK_BITS +: cache_pkg::CHUNK_BITS];
    end

    ////////////////////////////////////////
    // fill port
    ////////////////////////////////////////

    // a fill always carries the whole line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (fill_i.valid) begin
            line_valid[fill_i.index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            line_tag[fill_i.index]  <= fill_i.tag;
            line_data[fill_i.index] <= fill_i.data;
        end
    end

endmodule

// ==== design/consumer_port.sv ====
`timescale 1ns/1ps

module consumer_port (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::cons_req_t  req_i,
    output cache_pkg::cons_rsp_t  rsp_o,
    input  logic                  lookup_hit_i,
    input  cache_pkg::chunk_t     lookup_data_i,
    output logic                  miss_o
);

    cache_pkg::port_state_e state;
    logic                   ack_q;
    cache_pkg::chunk_t      data_q;
    logic                   answer;

    // answer a fresh request or a pending miss once the line is present
    // req stays high in PORT_MISS by the four-phase rule
    assign answer = lookup_hit_i &&
                    ((state == cache_pkg::PORT_IDLE && req_i.req) ||
                     (state == cache_pkg::PORT_MISS));

    // pending miss, drops in the cycle the refill lands
    assign miss_o = (state == cache_pkg::PORT_MISS) && !lookup_hit_i;

    ////////////////////////////////////////
    // request FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cache_pkg::PORT_IDLE;
            ack_q <= 1'b0;
        end else begin
            case (state)
                cache_pkg::PORT_IDLE: begin
                    if (answer) begin
                        ack_q <= 1'b1;
                        state <= cache_pkg::PORT_RELAY;
                    end else if (req_i.req) begin
                        // line absent, wait for a refill
                        state <= cache_pkg::PORT_MISS;
                    end
                end
                cache_pkg::PORT_MISS: begin
                    if (answer) begin
                        ack_q <= 1'b1;
                        state <= cache_pkg::PORT_RELAY;
                    end
                end
                cache_pkg::PORT_RELAY: begin
                    // hold ack until the consumer lets go
                    if (!req_i.req) begin
                        ack_q <= 1'b0;
                        state <= cache_pkg::PORT_IDLE;
                    end
                end
                default: begin
                    ack_q <= 1'b0;
                    state <= cache_pkg::PORT_IDLE;
                end
            endcase
        end
    end

    // read data register
    always_ff @(posedge clk) begin
        if (answer) begin
            data_q <= lookup_data_i;
        end
    end

    assign rsp_o = '{ack: ack_q, data: data_q};

endmodule

// ==== design/miss_arbiter.sv ====
`timescale 1ns/1ps

module miss_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    miss_i [cache_pkg::NUM_CONSUMERS],
    input  cache_pkg::addr_t        cons_addr_i [cache_pkg::NUM_CONSUMERS],
    input  logic                    busy_i,
    output cache_pkg::refill_cmd_t  cmd_o
);

    // last consumer that won an offer
    cache_pkg::consumer_id_t last_q;
    cache_pkg::consumer_id_t cand;
    cache_pkg::consumer_id_t winner;
    logic                    found;
    logic                    offer;

    // search starts just after the last winner
    always_comb begin
        found  = 1'b0;
        winner = last_q;
        cand   = last_q;
        for (int i = 1; i <= cache_pkg::NUM_CONSUMERS; i++) begin
            cand = cache_pkg::consumer_id_t'((int'(last_q) + i) % cache_pkg::NUM_CONSUMERS);
            if (!found && miss_i[cand]) begin
                found  = 1'b1;
                winner = cand;
            end
        end
    end

    // offer only to an idle engine
    assign offer = found && !busy_i;

    // line base address, offset bits cleared
    assign cmd_o = '{valid: offer,
                     addr: {cons_addr_i[winner][cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS],
                            {cache_pkg::OFFSET_BITS{1'b0}}}};

    // pointer starts at the top so consumer 0 goes first after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_q <= cache_pkg::consumer_id_t'(cache_pkg::NUM_CONSUMERS - 1);
        end else if (offer) begin
            last_q <= winner;
        end
    end

endmodule

// ==== refill/refill_engine.sv ====
`timescale 1ns/1ps

module refill_engine (
    input  logic                    clk,
    input  logic                    reset,
    input  cache_pkg::refill_cmd_t  cmd_i,
    output logic                    busy_o,
    output cache_pkg::mem_req_t     mem_req_o,
    input  cache_pkg::mem_rsp_t     mem_rsp_i,
    output cache_pkg::line_fill_t   fill_o
);

    cache_pkg::refill_state_e state;
    // chunk being fetched
    cache_pkg::offset_t       chunk;
    logic                     req_q;
    // line base address of the current refill
    cache_pkg::addr_t         base_q;
    // line assembly buffer
    cache_pkg::line_data_t    buffer;
    logic                     last_chunk;

    assign last_chunk = (chunk == cache_pkg::offset_t'(cache_pkg::NUM_CHUNKS - 1));
    assign busy_o     = (state != cache_pkg::RF_IDLE);

    ////////////////////////////////////////
    // memory side FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cache_pkg::RF_IDLE;
            chunk <= '0;
            req_q <= 1'b0;
        end else begin
            case (state)
                cache_pkg::RF_IDLE: begin
                    // any valid offer is taken
                    if (cmd_i.valid) begin
                        chunk <= '0;
                        req_q <= 1'b1;
                        state <= cache_pkg::RF_REQ;
                    end
                end
                cache_pkg::RF_REQ: begin
                    // phase 2 seen, release req
                    if (mem_rsp_i.ack) begin
                        req_q <= 1'b0;
                        state <= cache_pkg::RF_RELEASE;
                    end
                end
                cache_pkg::RF_RELEASE: begin
                    // wait for memory to drop ack before the next chunk
                    if (!mem_rsp_i.ack) begin
                        if (last_chunk) begin
                            state <= cache_pkg::RF_COMMIT;
                        end else begin
                            chunk <= chunk + 1'b1;
                            req_q <= 1'b1;
                            state <= cache_pkg::RF_REQ;
                        end
                    end
                end
                cache_pkg::RF_COMMIT: begin
                    // single cycle fill
                    state <= cache_pkg::RF_IDLE;
                end
                default: begin
                    req_q <= 1'b0;
                    state <= cache_pkg::RF_IDLE;
                end
            endcase
        end
    end

    // capture line base and returned chunks
    always_ff @(posedge clk) begin
        if (state == cache_pkg::RF_IDLE && cmd_i.valid) begin
            base_q <= cmd_i.addr;
        end
        if (state == cache_pkg::RF_REQ && mem_rsp_i.ack) begin
            buffer[chunk * cache_pkg::CHUNK_BITS +: cache_pkg::CHUNK_BITS] <= mem_rsp_i.data;
        end
    end

    // ascending offsets within the line, stable while req is high
    assign mem_req_o = '{req: req_q,
                         addr: {base_q[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS], chunk}};

    assign fill_o = '{valid: (state == cache_pkg::RF_COMMIT),
                      index: base_q[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS],
                      tag: base_q[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS],
                      data: buffer};

endmodule

// ==== design/arbiter_cache.sv ====
`timescale 1ns/1ps

module arbiter_cache (
    input  logic                  clk,
    input  logic                  reset,
    input  cache_pkg::cons_req_t  cons_req_i [cache_pkg::NUM_CONSUMERS],
    output cache_pkg::cons_rsp_t  cons_rsp_o [cache_pkg::NUM_CONSUMERS],
    output cache_pkg::mem_req_t   mem_req_o,
    input  cache_pkg::mem_rsp_t   mem_rsp_i
);

    // lookup path, one entry per consumer
    cache_pkg::addr_t       lookup_addr [cache_pkg::NUM_CONSUMERS];
    logic                   lookup_hit [cache_pkg::NUM_CONSUMERS];
    cache_pkg::chunk_t      lookup_data [cache_pkg::NUM_CONSUMERS];
    // pending misses toward the arbiter
    logic                   miss [cache_pkg::NUM_CONSUMERS];
    // refill path
    cache_pkg::refill_cmd_t refill_cmd;
    logic                   refill_busy;
    cache_pkg::line_fill_t  line_fill;

    line_store u_line_store (
        .clk           (clk),
        .reset         (reset),
        .lookup_addr_i (lookup_addr),
        .lookup_hit_o  (lookup_hit),
        .lookup_data_o (lookup_data),
        .fill_i        (line_fill)
    );

    for (genvar g = 0; g < cache_pkg::NUM_CONSUMERS; g++) begin : g_port
        // each port looks up its own request address
        assign lookup_addr[g] = cons_req_i[g].addr;

        consumer_port u_consumer_port (
            .clk           (clk),
            .reset         (reset),
            .req_i         (cons_req_i[g]),
            .rsp_o         (cons_rsp_o[g]),
            .lookup_hit_i  (lookup_hit[g]),
            .lookup_data_i (lookup_data[g]),
            .miss_o        (miss[g])
        );
    end

    miss_arbiter u_miss_arbiter (
        .clk         (clk),
        .reset       (reset),
        .miss_i      (miss),
        .cons_addr_i (lookup_addr),
        .busy_i      (refill_busy),
        .cmd_o       (refill_cmd)
    );

    refill_engine u_refill_engine (
        .clk       (clk),
        .reset     (reset),
        .cmd_i     (refill_cmd),
        .busy_o    (refill_busy),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i),
        .fill_o    (line_fill)
    );

endmodule

// ==== verification/tb_arbiter_cache.sv ====
`timescale 1ns/1ps

module tb_arbiter_cache;

    // cycles allowed for any single wait
    localparam int TIMEOUT = 200;
    // edges counted after the drive edge until a hit's ack is seen
    localparam int HIT_WAIT = 2;

    logic                 clk;
    logic                 reset;
    cache_pkg::cons_req_t cons_req [cache_pkg::NUM_CONSUMERS];
    cache_pkg::cons_rsp_t cons_rsp [cache_pkg::NUM_CONSUMERS];
    cache_pkg::mem_req_t  mem_req;
    cache_pkg::mem_rsp_t  mem_rsp;

    // reference model, valid and tag per line
    logic                 model_valid [cache_pkg::NUM_LINES];
    cache_pkg::tag_t      model_tag [cache_pkg::NUM_LINES];
    // memory reads still to come, in order
    cache_pkg::addr_t     exp_mem [$];
    logic                 check_mem;
    // small address pool, a few indices shared by several tags
    cache_pkg::addr_t     pool [8];

    // memory responder state
    int                   mem_delay;
    cache_pkg::addr_t     last_mem_addr;

    // handshake history from the previous edge
    logic                 prev_ack [cache_pkg::NUM_CONSUMERS];
    logic                 prev_req [cache_pkg::NUM_CONSUMERS];
    logic                 prev_mreq;
    logic                 prev_mack;
    cache_pkg::addr_t     prev_maddr;

    arbiter_cache u_arbiter_cache (
        .clk        (clk),
        .reset      (reset),
        .cons_req_i (cons_req),
        .cons_rsp_o (cons_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // checks and helpers
    ////////////////////////////////////////

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_chunk(input string name, input cache_pkg::chunk_t got,
                               input cache_pkg::chunk_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t got,
                              input cache_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // memory content rule
    function automatic cache_pkg::chunk_t mem_data(input cache_pkg::addr_t a);
        return cache_pkg::chunk_t'(a) ^ cache_pkg::chunk_t'(8'hA5);
    endfunction

    function automatic logic model_hit(input cache_pkg::addr_t a);
        cache_pkg::index_t idx;
        idx = a[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
        return model_valid[idx] &&
               (model_tag[idx] == a[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS]);
    endfunction

    // mostly pool addresses, now and then any address
    function automatic cache_pkg::addr_t pick_addr();
        int r;
        r = $urandom_range(0, 9);
        if (r < 8) begin
            return pool[r];
        end
        return cache_pkg::addr_t'($urandom);
    endfunction

    // one refill reads every chunk at ascending offsets
    task automatic expect_refill(input cache_pkg::addr_t a);
        for (int k = 0; k < cache_pkg::NUM_CHUNKS; k++) begin
            exp_mem.push_back({a[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS],
                               cache_pkg::offset_t'(k)});
        end
    endtask

    // one four-phase read, predict turns on the model checks
    task automatic cache_read(input cache_pkg::consumer_id_t id, input cache_pkg::addr_t addr,
                              input logic predict);
        int   waited;
        logic hit;
        hit = model_hit(addr);
        if (predict && !hit) begin
            expect_refill(addr);
        end
        @(posedge clk);
        cons_req[id] <= '{req: 1'b1, addr: addr};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error($sformatf("timeout: consumer %0d got no ack for %h", id, addr));
            end
        end while (!cons_rsp[id].ack);
        check_chunk("cons_rsp_o.data", cons_rsp[id].data, mem_data(addr));
        if (predict && hit && waited != HIT_WAIT) begin
            stop_with_error($sformatf("hit on %h answered after %0d cycles instead of %0d",
                                      addr, waited, HIT_WAIT));
        end
        if (predict && exp_mem.size() != 0) begin
            stop_with_error($sformatf("refill for %h skipped memory reads", addr));
        end
        cons_req[id] <= '{req: 1'b0, addr: addr};
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error($sformatf("timeout: consumer %0d ack stayed high", id));
            end
        end while (cons_rsp[id].ack);
    endtask

    task automatic random_reads(input cache_pkg::consumer_id_t id, input int count);
        repeat (count) begin
            repeat ($urandom_range(0, 4)) @(posedge clk);
            cache_read(id, pick_addr(), 1'b0);
        end
    endtask

    ////////////////////////////////////////
    // memory responder and handshake monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            mem_rsp   <= '0;
            mem_delay = 0;
        end else if (!mem_rsp.ack) begin
            if (mem_req.req && mem_delay == 0) begin
                last_mem_addr = mem_req.addr;
                if (check_mem) begin
                    if (exp_mem.size() == 0) begin
                        stop_with_error($sformatf("unexpected memory read of %h", mem_req.addr));
                    end
                    check_addr("mem_req_o.addr", mem_req.addr, exp_mem.pop_front());
                end
                mem_rsp <= '{ack: 1'b1, data: mem_data(mem_req.addr)};
            end else if (mem_req.req) begin
                mem_delay--;
            end
        end else if (!mem_req.req) begin
            mem_rsp.ack <= 1'b0;
            mem_delay = $urandom_range(0, 5);
            // fourth phase of the last chunk, the line counts as filled
            if (last_mem_addr[0 +: cache_pkg::OFFSET_BITS] ==
                cache_pkg::offset_t'(cache_pkg::NUM_CHUNKS - 1)) begin
                model_valid[last_mem_addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS]] = 1'b1;
                model_tag[last_mem_addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS]] =
                    last_mem_addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cache_pkg::NUM_CONSUMERS; i++) begin
                prev_ack[i] = 1'b0;
                prev_req[i] = 1'b0;
            end
            prev_mreq  = 1'b0;
            prev_mack  = 1'b0;
            prev_maddr = '0;
        end else begin
            for (int i = 0; i < cache_pkg::NUM_CONSUMERS; i++) begin
                if (cons_rsp[i].ack && !prev_ack[i]) begin
                    check_bit("cons_req_i.req at ack rise", cons_req[i].req, 1'b1);
                end
                if (!cons_rsp[i].ack && prev_ack[i]) begin
                    check_bit("cons_req_i.req before ack fall", prev_req[i], 1'b0);
                end
                prev_ack[i] = cons_rsp[i].ack;
                prev_req[i] = cons_req[i].req;
            end
            // memory req held with a stable address until ack
            if (prev_mreq && !prev_mack) begin
                check_bit("mem_req_o.req before ack", mem_req.req, 1'b1);
                check_addr("mem_req_o.addr before ack", mem_req.addr, prev_maddr);
            end
            if (mem_req.req && !prev_mreq) begin
                check_bit("mem_rsp_i.ack at req rise", mem_rsp.ack, 1'b0);
            end
            prev_mreq  = mem_req.req;
            prev_mack  = mem_rsp.ack;
            prev_maddr = mem_req.addr;
        end
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        cache_pkg::addr_t  a0;
        cache_pkg::addr_t  a1;
        cache_pkg::tag_t   t0;
        cache_pkg::index_t idx;
        void'($urandom(95629));
        reset     = 1'b1;
        check_mem = 1'b0;
        mem_rsp   = '0;
        for (int i = 0; i < cache_pkg::NUM_CONSUMERS; i++) begin
            cons_req[i] = '0;
        end
        for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        for (int i = 0; i < 8; i++) begin
            pool[i] = {cache_pkg::tag_t'($urandom), cache_pkg::index_t'(i % 3),
                       cache_pkg::offset_t'($urandom)};
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // quiet outputs before any request
        repeat (8) begin
            @(posedge clk);
            check_bit("cons_rsp_o[0].ack after reset", cons_rsp[0].ack, 1'b0);
            check_bit("cons_rsp_o[1].ack after reset", cons_rsp[1].ack, 1'b0);
            check_bit("mem_req_o.req after reset", mem_req.req, 1'b0);
        end

        // both consumers miss together, consumer 0 refilled first
        check_mem = 1'b1;
        a0 = pick_addr();
        a1 = {cache_pkg::tag_t'($urandom),
              a0[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS] + 1'b1,
              cache_pkg::offset_t'($urandom)};
        expect_refill(a0);
        expect_refill(a1);
        fork
            cache_read(0, a0, 1'b0);
            cache_read(1, a1, 1'b0);
        join
        if (exp_mem.size() != 0) begin
            stop_with_error("parallel misses did not read both lines from memory");
        end

        // consumer 0 alone, hit timing and refill addresses
        repeat (60) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            cache_read(0, pick_addr(), 1'b1);
        end

        // same index, two tags, read in turn
        idx = cache_pkg::index_t'($urandom);
        t0  = cache_pkg::tag_t'($urandom);
        repeat (3) begin
            cache_read(0, {t0, idx, 1'b0}, 1'b1);
            cache_read(0, {t0 + 1'b1, idx, 1'b1}, 1'b1);
        end

        // random traffic on both consumers
        check_mem = 1'b0;
        fork
            random_reads(0, 200);
            random_reads(1, 200);
        join

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
common/cache_pkg.sv
design/line_store.sv
design/consumer_port.sv
design/miss_arbiter.sv
refill/refill_engine.sv
design/arbiter_cache.sv
verification/tb_arbiter_cache.sv

// ==== Bender.yml ====
package:
  name: arbiter_cache

sources:
  # shared package first
  - common/cache_pkg.sv
  # cache blocks
  - design/line_store.sv
  - design/consumer_port.sv
  - design/miss_arbiter.sv
  - refill/refill_engine.sv
  # top level
  - design/arbiter_cache.sv
  # testbench
  - target: test
    files:
      - verification/tb_arbiter_cache.sv
